// File: design/cpu8_pkg.sv
package cpu8_pkg;

    localparam int DATA_W    = 8;  // Bus and register width
    localparam int ADDR_W    = 4;  // Memory address width
    localparam int MEM_DEPTH = 16; // Bytes of program/data memory

    // Pad constants
    localparam logic [7:0] UIO_OE_MASK = 8'b0011_1110; // uio[5:1] driven, rest are inputs
    localparam logic [7:0] OUT_RESET   = 8'h00;        // Output register value after reset

    // Upper nibble of every instruction byte
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_LDA = 4'd1,  // A <= mem[addr]
        OP_ADD = 4'd2,  // A <= A + mem[addr], flags
        OP_SUB = 4'd3,  // A <= A - mem[addr], flags
        OP_STA = 4'd4,  // mem[addr] <= A
        OP_LDI = 4'd5,  // A <= imm
        OP_JMP = 4'd6,
        OP_JC  = 4'd7,  // Jump on carry
        OP_JZ  = 4'd8,  // Jump on zero
        OP_OUT = 4'd14, // Output register <= A
        OP_HLT = 4'd15
    } opcode_t;

    // Loader and fetch/execute states
    typedef enum logic [3:0] {
        S_IDLE,
        S_LOAD_REQ,   // Ready high, host byte into MDR
        S_LOAD_ADDR,  // Byte counter into MAR
        S_LOAD_WRITE, // MDR into memory
        S_LOAD_DONE,  // Wait for programming to drop
        S_T1,
        S_T2,
        S_T3,
        S_T4,
        S_T5,
        S_HALT
    } seq_state_t;

    // Source that drives the shared bus
    typedef enum logic [2:0] {
        BUS_NONE, // Bus reads as zero
        BUS_PC,
        BUS_MEM,
        BUS_IR,   // Operand nibble, zero-extended
        BUS_ACC,
        BUS_ALU,
        BUS_UI    // Host byte from the pads
    } bus_src_t;

endpackage

// File: design/control_sequencer.sv
module control_sequencer
    import cpu8_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              programming,     // uio_in[0] from the host
    input  logic [DATA_W-1:0] ui_byte,
    input  opcode_t           opcode,          // From the IR
    input  logic              carry,
    input  logic              zero,
    output logic              pc_inc,
    output logic              pc_load,
    output logic              pc_clr,
    output logic              mar_load,
    output logic              mar_from_loader, // MAR takes load_addr instead of the bus
    output logic              mdr_load,
    output logic              mem_write,
    output logic              ir_load,
    output logic              acc_load,
    output logic              b_load,
    output logic              alu_sub,
    output logic              flags_load,
    output logic              flags_clr,
    output logic              out_load,
    output bus_src_t          bus_sel,
    output logic [ADDR_W-1:0] load_addr,
    output logic              ready,
    output logic              done_load,
    output logic              halted
);

    seq_state_t        state, next_state;
    logic              prog_q;      // Programming, one cycle late
    logic              prog_rise;
    logic              prog_fall;
    logic              run_start;   // Leaving the loader for T1
    logic [ADDR_W-1:0] load_cnt;    // Loader byte counter
    logic              load_last;
    logic              unused_ui;

    // Host byte never passes through here, the top-level mux routes it
    assign unused_ui = ^ui_byte;

    assign prog_rise = programming & ~prog_q;
    assign prog_fall = ~programming & prog_q;
    assign load_last = (load_cnt == ADDR_W'(MEM_DEPTH - 1));

    // Run starts on the programming fall, also when the load finishes after an early drop
    assign run_start = ((state == S_IDLE) && prog_fall) ||
                       ((state == S_LOAD_DONE) && !programming);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            prog_q   <= 1'b0;
            load_cnt <= '0;
            halted   <= 1'b0;
        end else begin
            state  <= next_state;
            prog_q <= programming;
            // HF set as HLT leaves T3, cleared by a new load or run
            if (prog_rise || run_start) begin
                halted <= 1'b0;
            end else if ((state == S_T3) && (opcode == OP_HLT)) begin
                halted <= 1'b1;
            end
            if (prog_rise) begin
                load_cnt <= '0;               // Every new load begins at byte 0
            end else if (state == S_LOAD_WRITE) begin
                load_cnt <= load_cnt + 1'b1;
            end
        end
    end

    // Next state
    always_comb begin
        next_state = state;
        if (prog_rise) begin
            next_state = S_LOAD_REQ;          // Abort whatever runs and reload
        end else begin
            case (state)
                S_IDLE:       if (run_start) next_state = S_T1;
                S_LOAD_REQ:   next_state = S_LOAD_ADDR;
                S_LOAD_ADDR:  next_state = S_LOAD_WRITE;
                S_LOAD_WRITE: next_state = load_last ? S_LOAD_DONE : S_LOAD_REQ;
                S_LOAD_DONE:  if (run_start) next_state = S_T1;
                S_T1:         next_state = S_T2;
                S_T2:         next_state = S_T3;
                S_T3:         next_state = (opcode == OP_HLT) ? S_HALT : S_T4;
                S_T4:         next_state = S_T5;
                S_T5:         next_state = S_T1;
                S_HALT:       next_state = S_HALT; // Only a new load leaves
                default:      next_state = S_IDLE;
            endcase
        end
    end

    // Strobes and bus source
    always_comb begin
        pc_inc          = 1'b0;
        pc_load         = 1'b0;
        mar_load        = 1'b0;
        mar_from_loader = 1'b0;
        mdr_load        = 1'b0;
        mem_write       = 1'b0;
        ir_load         = 1'b0;
        acc_load        = 1'b0;
        b_load          = 1'b0;
        alu_sub         = 1'b0;
        flags_load      = 1'b0;
        out_load        = 1'b0;
        bus_sel         = BUS_NONE;
        case (state)
            S_LOAD_REQ: begin
                bus_sel  = BUS_UI;            // Host byte into the MDR
                mdr_load = 1'b1;
            end
            S_LOAD_ADDR: begin
                mar_load        = 1'b1;
                mar_from_loader = 1'b1;
            end
            S_LOAD_WRITE: mem_write = 1'b1;
            S_T1: begin
                bus_sel  = BUS_PC;            // Fetch address
                mar_load = 1'b1;
            end
            S_T2: begin
                bus_sel = BUS_MEM;
                ir_load = 1'b1;
                pc_inc  = 1'b1;
            end
            S_T3: begin
                case (opcode)
                    OP_LDA, OP_ADD, OP_SUB, OP_STA: begin
                        bus_sel  = BUS_IR;    // Operand is the data address
                        mar_load = 1'b1;
                    end
                    OP_LDI: begin
                        bus_sel  = BUS_IR;
                        acc_load = 1'b1;
                    end
                    OP_JMP: begin
                        bus_sel = BUS_IR;
                        pc_load = 1'b1;
                    end
                    OP_JC: begin
                        bus_sel = BUS_IR;
                        pc_load = carry;
                    end
                    OP_JZ: begin
                        bus_sel = BUS_IR;
                        pc_load = zero;
                    end
                    OP_OUT: begin
                        bus_sel  = BUS_ACC;
                        out_load = 1'b1;
                    end
                    default: ;                // NOP, HLT and spare codes
                endcase
            end
            S_T4: begin
                case (opcode)
                    OP_LDA: begin
                        bus_sel  = BUS_MEM;
                        acc_load = 1'b1;
                    end
                    OP_ADD, OP_SUB: begin
                        bus_sel = BUS_MEM;    // Operand into B
                        b_load  = 1'b1;
                    end
                    OP_STA: begin
                        bus_sel  = BUS_ACC;   // A into the MDR
                        mdr_load = 1'b1;
                    end
                    default: ;
                endcase
            end
            S_T5: begin
                case (opcode)
                    OP_ADD, OP_SUB: begin
                        bus_sel    = BUS_ALU;
                        alu_sub    = (opcode == OP_SUB);
                        acc_load   = 1'b1;
                        flags_load = 1'b1;
                    end
                    OP_STA:  mem_write = 1'b1;
                    default: ;
                endcase
            end
            default: ;                        // Idle, load done and halt drive nothing
        endcase
    end

    assign pc_clr    = run_start;
    assign flags_clr = run_start;
    assign load_addr = load_cnt;
    assign ready     = (state == S_LOAD_REQ);  // One cycle per byte
    assign done_load = (state == S_LOAD_DONE);

endmodule

// File: design/fetch_unit.sv
module fetch_unit
    import cpu8_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] bus,
    input  logic              pc_inc,
    input  logic              pc_load,          // Jump target from the bus
    input  logic              pc_clr,
    input  logic              mar_load,
    input  logic              mar_from_loader,
    input  logic [ADDR_W-1:0] load_addr,        // Loader byte counter
    input  logic              ir_load,
    output logic [DATA_W-1:0] pc_value,
    output logic [ADDR_W-1:0] mem_addr,
    output opcode_t           opcode,
    output logic [DATA_W-1:0] operand
);

    logic [ADDR_W-1:0] pc;
    logic [ADDR_W-1:0] mar;
    logic [DATA_W-1:0] ir;

    // Program counter, wraps at 16
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_clr) begin
            pc <= '0;                     // Run start
        end else if (pc_load) begin
            pc <= bus[ADDR_W-1:0];
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

    // Memory address register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_load) begin
            mar <= mar_from_loader ? load_addr : bus[ADDR_W-1:0];
        end
    end

    // Instruction register, clears to NOP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ir_load) begin
            ir <= bus;
        end
    end

    assign pc_value = {{(DATA_W-ADDR_W){1'b0}}, pc};
    assign mem_addr = mar;

    // Opcode in the upper nibble, address or immediate in the lower
    assign opcode  = opcode_t'(ir[DATA_W-1:DATA_W-4]);
    assign operand = {{(DATA_W-4){1'b0}}, ir[3:0]};

endmodule

// File: design/execute_unit.sv
module execute_unit
    import cpu8_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [DATA_W-1:0] bus,
    input  logic              acc_load,
    input  logic              b_load,
    input  logic              alu_sub,     // 0 add, 1 subtract
    input  logic              flags_load,
    input  logic              flags_clr,   // Run start
    input  logic              out_load,
    output logic [DATA_W-1:0] acc_value,
    output logic [DATA_W-1:0] alu_result,
    output logic [DATA_W-1:0] out_value,
    output logic              carry,
    output logic              zero
);

    logic [DATA_W-1:0] reg_a;
    logic [DATA_W-1:0] reg_b;
    logic [DATA_W-1:0] out_reg;
    logic [DATA_W-1:0] b_operand;   // B or its ones' complement
    logic [DATA_W:0]   sum;         // Ninth bit is the carry
    logic              cf, zf;

    // Accumulator; a new run starts from zero as well
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a <= '0;
        end else if (flags_clr) begin
            reg_a <= '0;
        end else if (acc_load) begin
            reg_a <= bus;
        end
    end

    // B only feeds the ALU
    always_ff @(posedge clk) begin
        if (b_load) begin
            reg_b <= bus;
        end
    end

    // Subtract as A + ~B + 1, so carry set means no borrow
    assign b_operand = alu_sub ? ~reg_b : reg_b;
    assign sum       = {1'b0, reg_a} + {1'b0, b_operand} + {{DATA_W{1'b0}}, alu_sub};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (flags_clr) begin
            cf <= 1'b0;
            zf <= 1'b0;
        end else if (flags_load) begin
            cf <= sum[DATA_W];
            zf <= (sum[DATA_W-1:0] == '0);
        end
    end

    // Output register drives uo_out directly
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_reg <= OUT_RESET;
        end else if (out_load) begin
            out_reg <= bus;
        end
    end

    assign acc_value  = reg_a;
    assign alu_result = sum[DATA_W-1:0];
    assign out_value  = out_reg;
    assign carry      = cf;
    assign zero       = zf;

endmodule

// File: design/program_memory.sv
module program_memory
    import cpu8_pkg::*;
(
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr,      // From the MAR
    input  logic [DATA_W-1:0] wdata,     // Bus value for the MDR
    input  logic              mdr_load,
    input  logic              write,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] mdr;               // Write-data register

    // MDR capture
    always_ff @(posedge clk) begin
        if (mdr_load) begin
            mdr <= wdata;
        end
    end

    // Write port, one byte per strobe
    always_ff @(posedge clk) begin
        if (write) begin
            mem[addr] <= mdr;
        end
    end

    // Read is combinational so T2 sees the byte at MAR in the same cycle
    assign rdata = mem[addr];

endmodule

// File: design/cpu8_top.sv
module cpu8_top
    import cpu8_pkg::*;
(
    input  logic [7:0] ui_in,    // Host bytes while programming
    input  logic [7:0] uio_in,   // Bit 0 is programming
    input  logic       ena,
    input  logic       clk,
    input  logic       rst_n,
    output logic [7:0] uo_out,   // Output register
    output logic [7:0] uio_out,  // Status bits
    output logic [7:0] uio_oe
);

    logic [DATA_W-1:0] bus;
    bus_src_t          bus_sel;

    // Strobes
    logic pc_inc, pc_load, pc_clr;
    logic mar_load, mar_from_loader, mdr_load, mem_write, ir_load;
    logic acc_load, b_load, alu_sub, flags_load, flags_clr, out_load;

    // Unit outputs
    logic [DATA_W-1:0] pc_value, mem_rdata, operand, acc_value, alu_result, out_value;
    logic [ADDR_W-1:0] load_addr, mem_addr;
    opcode_t           opcode;
    logic              carry, zero;
    logic              ready, done_load, halted;
    logic              unused_pins;

    // Bus mux replaces the tri-state bus
    always_comb begin
        case (bus_sel)
            BUS_PC:  bus = pc_value;
            BUS_MEM: bus = mem_rdata;
            BUS_IR:  bus = operand;
            BUS_ACC: bus = acc_value;
            BUS_ALU: bus = alu_result;
            BUS_UI:  bus = ui_in;
            default: bus = '0;            // Nobody drives
        endcase
    end

    control_sequencer u_seq (
        .clk, .rst_n,
        .programming (uio_in[0]),
        .ui_byte     (ui_in),
        .opcode, .carry, .zero,
        .pc_inc, .pc_load, .pc_clr,
        .mar_load, .mar_from_loader, .mdr_load, .mem_write, .ir_load,
        .acc_load, .b_load, .alu_sub, .flags_load, .flags_clr, .out_load,
        .bus_sel, .load_addr, .ready, .done_load, .halted
    );

    fetch_unit u_fetch (
        .clk, .rst_n, .bus,
        .pc_inc, .pc_load, .pc_clr,
        .mar_load, .mar_from_loader, .load_addr, .ir_load,
        .pc_value, .mem_addr, .opcode, .operand
    );

    execute_unit u_exec (
        .clk, .rst_n, .bus,
        .acc_load, .b_load, .alu_sub, .flags_load, .flags_clr, .out_load,
        .acc_value, .alu_result, .out_value, .carry, .zero
    );

    program_memory u_mem (
        .clk,
        .addr     (mem_addr),
        .wdata    (bus),
        .mdr_load,
        .write    (mem_write),
        .rdata    (mem_rdata)
    );

    // Pad mapping
    assign uo_out  = out_value;
    assign uio_out = {2'b00, halted, zero, carry, done_load, ready, 1'b0};
    assign uio_oe  = UIO_OE_MASK;

    assign unused_pins = &{ena, uio_in[7:1]}; // Lint sink

endmodule

// File: tests/clock_gen.sv
module clock_gen #(
    parameter int PERIOD       = 40, // Clock period in time units
    parameter int RESET_CYCLES = 3   // Rising edges with rst_n low
) (
    output logic clk,
    output logic rst_n
);

    // Free-running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset released on a rising edge, like every other DUT input
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// File: tests/cpu8_assert.sv
module cpu8_assert
    import cpu8_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input seq_state_t state,
    input logic       ready,
    input logic       halted,
    input logic       mem_write,
    input opcode_t    opcode,
    input bus_src_t   bus_sel,
    input logic       mar_load,
    input logic       mar_from_loader, // MAR fed by the loader, not the bus
    input logic       mdr_load,
    input logic       ir_load,
    input logic       acc_load,
    input logic       b_load,
    input logic       pc_load,
    input logic       out_load
);

    logic [6:0] bus_targets; // Registers that take the bus this cycle

    assign bus_targets = {mar_load & ~mar_from_loader, mdr_load, ir_load,
                          acc_load, b_load, pc_load, out_load};

    // One request cycle per byte
    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n) ready |=> !ready)
        else $error("ready held high for two cycles");

    a_one_target: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(bus_targets))
        else $error("more than one register loads from the bus");

    // A bus load always has a source behind it
    a_target_driven: assert property (@(posedge clk) disable iff (!rst_n)
        (|bus_targets) |-> (bus_sel != BUS_NONE))
        else $error("bus load with no bus source");

    a_halt_state: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> (state == S_HALT))
        else $error("halt flag outside the halt state");

    // Writes come from the loader or from STA in T5
    a_write_state: assert property (@(posedge clk) disable iff (!rst_n)
        mem_write |-> ((state == S_LOAD_WRITE) || (state == S_T5 && opcode == OP_STA)))
        else $error("memory write outside a write state");

endmodule

// File: tests/tb_cpu8.sv
module tb_cpu8
    import cpu8_pkg::*;
();

    localparam int N_PROGS        = 20;
    localparam int LOAD_LEN       = 3 * MEM_DEPTH;    // Three cycles per byte
    localparam int RUN_MAX        = 5 * 13 + 10;      // Longest run plus slack
    localparam int TIMEOUT_CYCLES = (N_PROGS + 3) * (LOAD_LEN + RUN_MAX + 10) + 200;

    logic       clk;
    logic       rst_n;
    logic [7:0] ui_in;
    logic [7:0] uio_in;      // Bit 0 is programming
    logic       ena;
    logic [7:0] uo_out;
    logic [7:0] uio_out;     // 1 ready, 2 done_load, 3 CF, 4 ZF, 5 HF
    logic [7:0] uio_oe;

    logic [7:0] prog_mem [MEM_DEPTH]; // Image for the next load
    logic [7:0] exp_outs [$];         // Model OUT values, repeats dropped
    logic [7:0] obs_outs [$];         // Changes seen on uo_out
    logic       exp_cf;
    logic       exp_zf;
    int         exp_steps;            // Instructions before HLT
    int         errors     = 0;
    int         err_mark   = 0;       // Error count when the test began
    int         tests_run  = 0;
    int         test_fails = 0;
    int         cycles     = 0;

    clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    cpu8_top UUT (
        .ui_in   (ui_in),
        .uio_in  (uio_in),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n),
        .uo_out  (uo_out),
        .uio_out (uio_out),
        .uio_oe  (uio_oe)
    );

    bind control_sequencer cpu8_assert u_assert (
        .clk (clk), .rst_n (rst_n), .state (state), .ready (ready), .halted (halted),
        .mem_write (mem_write), .opcode (opcode), .bus_sel (bus_sel),
        .mar_load (mar_load), .mar_from_loader (mar_from_loader), .mdr_load (mdr_load),
        .ir_load (ir_load), .acc_load (acc_load), .b_load (b_load),
        .pc_load (pc_load), .out_load (out_load)
    );

    // Watchdog over the whole run
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: CPU never halted");
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    function automatic logic [7:0] encode(opcode_t op, logic [3:0] arg);
        return {op, arg};
    endfunction

    // Twelve random instructions, HLT at 12, data in 13 to 15
    task automatic make_program();
        int kind;
        for (int i = 0; i < 12; i++) begin
            kind = $urandom_range(8, 0);
            case (kind)
                0: prog_mem[4'(i)] = encode(OP_LDA, 4'($urandom_range(15, 0)));
                1: prog_mem[4'(i)] = encode(OP_ADD, 4'($urandom_range(15, 0)));
                2: prog_mem[4'(i)] = encode(OP_SUB, 4'($urandom_range(15, 0)));
                3: prog_mem[4'(i)] = encode(OP_STA, 4'($urandom_range(15, 13))); // Data bytes only
                4: prog_mem[4'(i)] = encode(OP_LDI, 4'($urandom_range(15, 0)));
                5: prog_mem[4'(i)] = encode(OP_OUT, 4'($urandom_range(15, 0)));
                6: prog_mem[4'(i)] = encode(OP_JMP, 4'($urandom_range(12, i + 1))); // Forward
                7: prog_mem[4'(i)] = encode(OP_JC, 4'($urandom_range(12, i + 1)));
                default: prog_mem[4'(i)] = encode(OP_JZ, 4'($urandom_range(12, i + 1)));
            endcase
        end
        prog_mem[4'd12] = encode(OP_HLT, 4'd0);
        for (int i = 13; i < MEM_DEPTH; i++) begin
            prog_mem[4'(i)] = 8'($urandom);
        end
    endtask

    // Instruction-level interpreter of the program image
    task automatic run_model(input logic [7:0] start_out);
        logic [7:0] m [MEM_DEPTH];
        logic [3:0] pc;
        logic [3:0] arg;
        logic [7:0] a;
        logic [7:0] last;
        logic [8:0] sum;
        opcode_t    op;
        m         = prog_mem;
        pc        = 4'd0;
        a         = 8'd0;              // A starts cleared on every run
        last      = start_out;
        exp_cf    = 1'b0;
        exp_zf    = 1'b0;
        exp_steps = 0;
        exp_outs.delete();
        op = opcode_t'(m[pc][7:4]);
        while (op != OP_HLT && exp_steps < 64) begin
            arg = m[pc][3:0];
            pc  = pc + 4'd1;           // Wraps at 16
            exp_steps++;
            case (op)
                OP_LDA: a = m[arg];
                OP_ADD: begin
                    sum    = {1'b0, a} + {1'b0, m[arg]};
                    exp_cf = sum[8];
                    a      = sum[7:0];
                    exp_zf = (a == 8'd0);
                end
                OP_SUB: begin
                    exp_cf = (a >= m[arg]); // Carry means no borrow
                    a      = a - m[arg];
                    exp_zf = (a == 8'd0);
                end
                OP_STA: m[arg] = a;
                OP_LDI: a = {4'd0, arg};
                OP_JMP: pc = arg;
                OP_JC:  if (exp_cf) pc = arg;
                OP_JZ:  if (exp_zf) pc = arg;
                OP_OUT: begin
                    if (a != last) exp_outs.push_back(a);
                    last = a;
                end
                default: ;             // NOP and spare codes
            endcase
            op = opcode_t'(m[pc][7:4]);
        end
    endtask

    // Host side of the loader, ends on the edge where programming falls
    task automatic load_program();
        int pulses;
        int gap;                       // Cycles since the last ready
        pulses = 0;
        gap    = 0;
        @(posedge clk);
        uio_in <= 8'h01;
        ui_in  <= prog_mem[4'd0];
        while (pulses < MEM_DEPTH) begin
            @(negedge clk);
            gap++;
            if (uio_out[1]) begin
                if (pulses > 0) begin
                    check_eq(32'(gap), 32'd3, "ready spacing");
                end else begin
                    check_eq(32'(uio_out[5]), 32'd0, "halt flag during load");
                end
                check_eq(32'(uio_out[2]), 32'd0, "done_load before last byte");
                pulses++;
                gap = 0;
                @(posedge clk);
                ui_in <= prog_mem[4'(pulses)]; // Next byte, held through its ready cycle
            end
        end
        repeat (3) begin
            @(negedge clk);
            gap++;
            check_eq(32'(uio_out[1]), 32'd0, "extra ready pulse");
            check_eq(32'(uio_out[2]), 32'(gap == 3), "done_load rise");
        end
        repeat (4) begin
            @(negedge clk);
            check_eq(32'(uio_out[1]), 32'd0, "extra ready pulse");
            check_eq(32'(uio_out[2]), 32'd1, "done_load held");
        end
        @(posedge clk);
        uio_in <= 8'h00;               // Run starts
    endtask

    task automatic run_and_check();
        int         elapsed;
        logic [7:0] start_out;
        logic [7:0] last;
        elapsed = 0;
        obs_outs.delete();
        @(negedge clk);
        start_out = uo_out;
        last      = uo_out;
        run_model(start_out);
        while (!uio_out[5]) begin
            @(negedge clk);
            elapsed++;
            if (uo_out != last) begin
                obs_outs.push_back(uo_out);
                last = uo_out;
            end
        end
        check_eq(32'(elapsed), 32'(5 * exp_steps + 4), "cycles to halt");
        check_eq(32'(uio_out[3]), 32'(exp_cf), "carry flag at halt");
        check_eq(32'(uio_out[4]), 32'(exp_zf), "zero flag at halt");
        check_eq(32'(obs_outs.size()), 32'(exp_outs.size()), "number of output changes");
        for (int k = 0; k < obs_outs.size() && k < exp_outs.size(); k++) begin
            check_eq(32'(obs_outs[k]), 32'(exp_outs[k]), "output value");
        end
        check_eq(32'(uo_out), 32'(exp_outs.size() > 0 ? exp_outs[$] : start_out), "final output");
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors != err_mark) begin
            test_fails++;
            $display("Test %-12s FAIL (%0d errors)", name, errors - err_mark);
        end else begin
            $display("Test %-12s PASS", name);
        end
        err_mark = errors;
    endtask

    initial begin
        ui_in    <= 8'h00;
        uio_in   <= 8'h00;
        ena      <= 1'b1;
        void'($urandom(32'he2ce_6860));

        // Pads after reset
        while (rst_n !== 1'b1) @(negedge clk);
        @(negedge clk);
        check_eq(32'(uo_out), 32'd0, "uo_out after reset");
        check_eq(32'(uio_out), 32'd0, "uio_out after reset");
        check_eq(32'(uio_oe), 32'(UIO_OE_MASK), "uio_oe");
        report_test("reset");

        for (int p = 0; p < N_PROGS; p++) begin
            make_program();
            load_program();
            run_and_check();
            report_test($sformatf("program %0d", p));
        end

        // Abort a run early with a new load
        make_program();
        load_program();
        repeat ($urandom_range(6, 2)) @(negedge clk);
        make_program();
        load_program();
        run_and_check();
        report_test("reload");

        $display("Tests: %0d run, %0d failed, %0d errors", tests_run, test_fails, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: cpu8_top.f
design/cpu8_pkg.sv
design/control_sequencer.sv
design/fetch_unit.sv
design/execute_unit.sv
design/program_memory.sv
design/cpu8_top.sv
tests/clock_gen.sv
tests/cpu8_assert.sv
tests/tb_cpu8.sv

// File: Makefile
# Verilator build, run and lint for the accumulator CPU

VERILATOR  ?= verilator
TOP        ?= tb_cpu8
RTL_TOP    ?= cpu8_top
FILELIST   ?= cpu8_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall
FAIL_MSG   ?= Testbench failed

SIM_BIN  := $(BUILD_DIR)/V$(TOP)
SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter design/%,$(SRCS))

.PHONY: all build run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

build: $(SIM_BIN)

# Fails on a nonzero exit or on the fail message in the log
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
